// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ntt_top
FILELIST  := project.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: ntt_butterfly.sv
/* Cooley-Tukey butterfly mod q, purely combinational
   inputs must already be reduced below q */
`timescale 1ns/1ps

module ntt_butterfly (
    input  ntt_pkg::coef_t a,
    input  ntt_pkg::coef_t b,
    input  ntt_pkg::twid_t twiddle,
    output ntt_pkg::coef_t res_a,
    output ntt_pkg::coef_t res_b
);
    import ntt_pkg::*;

    logic [29:0] prod;
    logic [15:0] m_lo;
    logic [31:0] t_sum;
    logic [15:0] z;
    coef_t       r;
    logic [16:0] sum;

    // montgomery reduction of b * twiddle
    assign prod  = 30'(b) * 30'(twiddle);
    assign m_lo  = prod[15:0] * 16'(Q_NEG_INV);
    // low half of t_sum is zero by construction
    assign t_sum = 32'(prod) + 32'(m_lo) * 32'(Q);
    assign z     = t_sum[31:16];
    assign r     = (z >= 16'(Q)) ? z - 16'(Q) : z;

    // modular sum and difference
    assign sum   = 17'(a) + 17'(r);
    assign res_a = (sum >= 17'(Q)) ? coef_t'(sum - 17'(Q)) : coef_t'(sum);
    assign res_b = (a >= r) ? a - r : a + 16'(Q) - r;

    always_comb begin
        if (a < 16'(Q) && b < 16'(Q)) begin
            assert (res_a < 16'(Q) && res_b < 16'(Q))
                else $error("[ERROR] %0t butterfly result not reduced", $time);
        end
    end

endmodule

// File: ntt_coef_bank.sv
/* 128-entry coefficient register file with no reset on the data
   load shifts in one word at a time; compute writes back every cycle */
`timescale 1ns/1ps

module ntt_coef_bank (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  ntt_pkg::word_t  in_data,
    input  ntt_pkg::phase_t phase,
    input  ntt_pkg::step_t  step,
    output ntt_pkg::lanes_t lane_a,
    output ntt_pkg::lanes_t lane_b,
    input  ntt_pkg::lanes_t res_a,
    input  ntt_pkg::lanes_t res_b,
    input  ntt_pkg::idx_t   rd_idx,
    output ntt_pkg::coef_t  rd_data
);
    import ntt_pkg::*;

    coef_t coef [N_COEF];

    // pair addresses of the current step
    idx_t idx_a [N_LANE];
    idx_t idx_b [N_LANE];

    // all gathered operands below q
    logic lanes_ok;

    // --------------------------------------------------
    // gather
    // --------------------------------------------------
    always_comb begin
        int stage;
        int shift;
        int m;
        int j;

        stage = int'(step) / N_LANE;
        shift = N_STAGE - 1 - stage;
        lanes_ok = 1'b1;
        for (int l = 0; l < N_LANE; l++) begin
            m = N_LANE * (int'(step) % N_LANE) + l;
            // j = 2*L*block + (m mod L) with L a power of two
            j = ((m >> shift) << (shift + 1)) | (m & ((1 << shift) - 1));
            idx_a[l] = idx_t'(j);
            idx_b[l] = idx_t'(j + (1 << shift));
            lane_a[l] = coef[idx_a[l]];
            lane_b[l] = coef[idx_b[l]];
            if (lane_a[l] >= COEF_W'(Q) || lane_b[l] >= COEF_W'(Q)) begin
                lanes_ok = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // load shift and scatter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            // oldest word moves towards index 0
            for (int i = 0; i < N_COEF - N_LANE; i++) begin
                coef[i] <= coef[i + N_LANE];
            end
            for (int l = 0; l < N_LANE; l++) begin
                coef[N_COEF - N_LANE + l] <= COEF_W'(in_data[l*NIB_W +: NIB_W]);
            end
        end else if (phase == PH_COMPUTE) begin
            for (int l = 0; l < N_LANE; l++) begin
                coef[idx_a[l]] <= res_a[l];
                coef[idx_b[l]] <= res_b[l];
            end
        end
    end

    // drain read port
    assign rd_data = coef[rd_idx];

    // every operand fed to the butterflies is already reduced
    a_lanes_reduced: assert property (
        @(posedge clk) disable iff (!rst_n)
        phase == PH_COMPUTE |-> lanes_ok
    ) else $error("[ERROR] %0t butterfly operand not below q", $time);

endmodule

// File: ntt_ctrl.sv
/* frame FSM: collect 16 words, run 56 steps, then wait for the drain
   the source must hold in_valid low while busy */
`timescale 1ns/1ps

module ntt_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic            drain_done,
    output logic            load,
    output ntt_pkg::phase_t phase,
    output ntt_pkg::step_t  step,
    output logic            busy
);
    import ntt_pkg::*;

    logic [$clog2(N_WORD)-1:0] word_cnt;

    assign load = in_valid && (phase == PH_LOAD);
    assign busy = (phase != PH_LOAD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= PH_LOAD;
            word_cnt <= '0;
            step     <= '0;
        end else begin
            case (phase)
                PH_LOAD: begin
                    if (load) begin
                        // wraps to zero on the 16th word
                        word_cnt <= word_cnt + 1'b1;
                        if (int'(word_cnt) == N_WORD - 1) begin
                            phase <= PH_COMPUTE;
                        end
                    end
                end
                PH_COMPUTE: begin
                    if (int'(step) == N_STEP - 1) begin
                        step  <= '0;
                        phase <= PH_DRAIN;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                PH_DRAIN: begin
                    if (drain_done) begin
                        phase <= PH_LOAD;
                    end
                end
                default: phase <= PH_LOAD;
            endcase
        end
    end

    a_no_input_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> !busy
    ) else $error("[ERROR] %0t in_valid while busy", $time);

    a_step_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(step) < N_STEP
    ) else $error("[ERROR] %0t step out of range", $time);

endmodule

// File: ntt_out_stream.sv
/* in-order coefficient drain with credit flow control
   the sink may return at most as many credits as it has received */
`timescale 1ns/1ps

module ntt_out_stream (
    input  logic            clk,
    input  logic            rst_n,
    input  ntt_pkg::phase_t phase,
    input  logic            credit_return,
    output ntt_pkg::idx_t   rd_idx,
    input  ntt_pkg::coef_t  rd_data,
    output logic            out_valid,
    output ntt_pkg::coef_t  out_data,
    output logic            drain_done
);
    import ntt_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                send;

    // hold off while the done pulse is still visible to the controller
    assign send = (phase == PH_DRAIN) && (credits != '0) && !drain_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits    <= CREDIT_W'(CREDIT_MAX);
            rd_idx     <= '0;
            out_valid  <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            out_valid  <= send;
            drain_done <= send && (int'(rd_idx) == N_COEF - 1);
            if (send) begin
                // 127 wraps back to 0 for the next frame
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_data <= rd_data;
        end
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(credits) <= CREDIT_MAX
    ) else $error("[ERROR] %0t credit count above maximum", $time);

endmodule

// File: ntt_pkg.sv
/* shared constants and types for the 128-point NTT over q = 12289
   twiddles are in Montgomery form (w * 2^16 mod q); entry 0 is never read */
package ntt_pkg;

    // --------------------------------------------------
    // arithmetic
    // --------------------------------------------------
    localparam int Q         = 12289;
    localparam int Q_NEG_INV = 12287;    // -q^-1 mod 2^16

    localparam int COEF_W = 16;
    localparam int TWID_W = 14;
    localparam int WORD_W = 32;
    localparam int NIB_W  = 4;

    // --------------------------------------------------
    // frame geometry
    // --------------------------------------------------
    localparam int N_COEF  = 128;
    localparam int N_LANE  = 8;
    localparam int N_WORD  = N_COEF / N_LANE;
    localparam int N_STAGE = 7;
    localparam int N_STEP  = N_STAGE * N_COEF / (2 * N_LANE);

    // output credits held after reset
    localparam int CREDIT_MAX = 4;
    localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

    // indexed by 2^stage + block
    localparam int TWIDDLES [N_COEF] = '{
            0,  7888, 11060, 11208,  6960,  4342,  6275,  9759,
         1591,  6399,  9477,  5266,   586,  5825,  7538,  9710,
         1134,  6407,  1711,   965,  7099,  7674,  3743,  6442,
        10414,  8100,  1885,  1688,  1364, 10329, 10164,  9180,
        12210,  6240,   997,   117,  4783,  4407,  1549,  7072,
         2829,  6458,  4431,  8877,  7144,  2564,  5664,  4042,
        12189,   432, 10751,  1237,  7610,  1534,  3983,  7863,
         2181,  6308,  8720,  6570,  4843,  1690,    14,  3872,
         5569,  9368, 12163,  2019,  7543,  2315,  4673,  7340,
         1553,  1156,  8401, 11389,  1020,  2967, 10772,  7045,
         3316, 11236,  5285, 11578, 10637, 10086,  9493,  6180,
         9277,  6130,  3323,   883, 10469,   489,  1502,  2851,
        11061,  9729,  2742, 12241,  4970, 10481, 10078,  1195,
          730,  1762,  3854,  2030,  5892, 10922,  9020,  5274,
         9179,  3604,  3782, 10206,  3180,  3467,  4668,  2446,
         7613,  9386,   834,  7703,  6836,  3403,  5351, 12276
    };

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef logic [COEF_W-1:0]             coef_t;
    typedef logic [TWID_W-1:0]             twid_t;
    typedef logic [WORD_W-1:0]             word_t;
    typedef logic [$clog2(N_STEP)-1:0]     step_t;
    typedef logic [$clog2(N_COEF)-1:0]     idx_t;
    typedef logic [N_LANE-1:0][COEF_W-1:0] lanes_t;
    typedef logic [N_LANE-1:0][TWID_W-1:0] twids_t;

    typedef enum logic [1:0] {
        PH_LOAD,
        PH_COMPUTE,
        PH_DRAIN
    } phase_t;

endpackage

// File: ntt_top.sv
/* 128-point forward NTT mod 12289, one frame at a time
   load 16 words while busy is low; results leave in index order under credits */
`timescale 1ns/1ps

module ntt_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  ntt_pkg::word_t in_data,
    output logic           busy,
    output logic           out_valid,
    output ntt_pkg::coef_t out_data,
    input  logic           credit_return
);
    import ntt_pkg::*;

    logic   load;
    phase_t phase;
    step_t  step;
    lanes_t lane_a;
    lanes_t lane_b;
    lanes_t res_a;
    lanes_t res_b;
    twids_t twiddles;
    idx_t   rd_idx;
    coef_t  rd_data;
    logic   drain_done;

    ntt_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .drain_done (drain_done),
        .load       (load),
        .phase      (phase),
        .step       (step),
        .busy       (busy)
    );

    ntt_coef_bank u_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .in_data (in_data),
        .phase   (phase),
        .step    (step),
        .lane_a  (lane_a),
        .lane_b  (lane_b),
        .res_a   (res_a),
        .res_b   (res_b),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    ntt_twiddle_rom u_rom (
        .step     (step),
        .twiddles (twiddles)
    );

    // one butterfly per lane
    for (genvar l = 0; l < N_LANE; l++) begin : g_lane
        ntt_butterfly u_bfly (
            .a       (lane_a[l]),
            .b       (lane_b[l]),
            .twiddle (twiddles[l]),
            .res_a   (res_a[l]),
            .res_b   (res_b[l])
        );
    end

    ntt_out_stream u_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .phase         (phase),
        .credit_return (credit_return),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .drain_done    (drain_done)
    );

endmodule

// File: ntt_twiddle_rom.sv
/* twiddle lookup for the eight lanes of one compute step
   step must stay below N_STEP */
`timescale 1ns/1ps

module ntt_twiddle_rom (
    input  ntt_pkg::step_t  step,
    output ntt_pkg::twids_t twiddles
);
    import ntt_pkg::*;

    // --------------------------------------------------
    // lane l of step s runs butterfly m = 8*(s mod 8) + l
    // in stage s/8; its block is m / half-span
    // --------------------------------------------------
    always_comb begin
        int stage;
        int shift;
        int m;
        int blk;

        stage = int'(step) / N_LANE;
        // log2 of the half-span
        shift = N_STAGE - 1 - stage;
        for (int l = 0; l < N_LANE; l++) begin
            m   = N_LANE * (int'(step) % N_LANE) + l;
            blk = m >> shift;
            twiddles[l] = twid_t'(TWIDDLES[(1 << stage) + blk]);
        end
    end

endmodule

// File: project.f
ntt_pkg.sv
ntt_butterfly.sv
ntt_twiddle_rom.sv
ntt_coef_bank.sv
ntt_ctrl.sv
ntt_out_stream.sv
ntt_top.sv
tb_ntt_top.sv

// File: tb_ntt_top.sv
/* self-checking testbench for ntt_top with random, all-zero and all-15 frames
   credits come back after 0 to 7 cycles with one withheld stretch in frame 0 */
`timescale 1ns/1ps

module tb_ntt_top;
    import ntt_pkg::*;

    localparam int N_FRAMES    = 3;
    localparam int HOLD_AT     = 40;
    localparam int HOLD_CYCLES = 24;
    localparam int WATCHDOG_NS = N_FRAMES * (N_WORD + N_STEP + N_COEF * 9) * 4 * 2;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    word_t in_data;
    logic  busy;
    logic  out_valid;
    coef_t out_data;
    logic  credit_return = 1'b0;

    int frame_coefs [N_COEF];
    int expected [N_COEF];
    int r_inv;
    int words_taken = 0;
    int cyc = 0;
    int rx_total = 0;
    int ret_total = 0;
    int rx_in_frame = 0;
    int frames_done = 0;
    int hold_left = 0;
    int due_q [$];
    bit frame_complete = 1'b0;
    bit fall_pending = 1'b0;
    bit busy_q = 1'b0;

    ntt_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .busy          (busy),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .credit_return (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_check(input string what);
        $display("[ERROR] %0t %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // 2^-16 mod q by plain search
    function automatic int find_r_inv();
        for (int x = 1; x < Q; x++) begin
            if ((x * 65536) % Q == 1) begin
                return x;
            end
        end
        return 0;
    endfunction

    // --------------------------------------------------
    // reference model of the seven in-place Cooley-Tukey stages
    // --------------------------------------------------
    task automatic compute_reference();
        int a [N_COEF];
        int half;
        int blk;
        int j;
        int r;
        int x;
        a = frame_coefs;
        for (int t = 0; t < N_STAGE; t++) begin
            half = (N_COEF / 2) >> t;
            for (int m = 0; m < N_COEF / 2; m++) begin
                blk = m / half;
                j   = 2 * half * blk + m % half;
                r   = int'((longint'(a[j + half]) * TWIDDLES[(1 << t) + blk] % Q)
                           * r_inv % Q);
                x   = a[j];
                a[j]        = (x + r) % Q;
                a[j + half] = (x - r + Q) % Q;
            end
        end
        expected = a;
    endtask

    // kind 0 is random, 1 all zero and anything else all 15
    task automatic send_frame(input int kind);
        int    gaps [N_WORD];
        word_t w;
        for (int i = 0; i < N_COEF; i++) begin
            case (kind)
                0:       frame_coefs[i] = int'($urandom_range(15, 0));
                1:       frame_coefs[i] = 0;
                default: frame_coefs[i] = 15;
            endcase
        end
        for (int k = 0; k < N_WORD; k++) begin
            gaps[k] = int'($urandom_range(2, 0));
        end
        compute_reference();
        for (int k = 0; k < N_WORD; k++) begin
            w = '0;
            for (int i = 0; i < N_LANE; i++) begin
                w[i*NIB_W +: NIB_W] = NIB_W'(frame_coefs[k*N_LANE + i]);
            end
            repeat (gaps[k]) begin
                @(negedge clk);
                in_valid <= 1'b0;
            end
            @(negedge clk);
            in_valid <= 1'b1;
            in_data  <= w;
        end
        @(negedge clk);
        in_valid <= 1'b0;
    endtask

    // words as the DUT takes them
    always @(posedge clk) begin
        if (rst_n && in_valid && !busy) begin
            words_taken <= words_taken + 1;
        end
    end

    // --------------------------------------------------
    // output monitor and credit sink
    // --------------------------------------------------
    always @(negedge clk) begin
        int idx;
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else begin
            cyc++;
            if (words_taken < N_WORD) begin
                assert (!busy && !out_valid)
                    else fail_check("busy or out_valid high before the first frame");
            end
            if (busy && !busy_q) begin
                rx_in_frame    = 0;
                frame_complete = 1'b0;
            end
            if (fall_pending) begin
                assert (!busy) else fail_check("busy still high after the 128th output");
                fall_pending = 1'b0;
            end
            if (out_valid) begin
                assert (!frame_complete) else fail_check("more than 128 outputs in one frame");
                assert (out_data < 16'(Q))
                    else fail_check($sformatf("out_data %0d is not below q", out_data));
                assert (int'(out_data) == expected[rx_in_frame])
                    else fail_check($sformatf("coef %0d is %0d, expected %0d",
                                              rx_in_frame, out_data, expected[rx_in_frame]));
                rx_in_frame++;
                rx_total++;
                assert (rx_total - ret_total <= CREDIT_MAX)
                    else fail_check("more coefficients outstanding than credits");
                due_q.push_back(cyc + int'($urandom_range(7, 0)));
                if (rx_in_frame == N_COEF) begin
                    frame_complete = 1'b1;
                    fall_pending   = 1'b1;
                    frames_done++;
                end
                if (frames_done == 0 && rx_in_frame == HOLD_AT) begin
                    hold_left = HOLD_CYCLES;
                end
            end
            busy_q = busy;

            // one return per cycle at most
            idx = -1;
            if (hold_left > 0) begin
                hold_left--;
                if (hold_left == 0) begin
                    assert (rx_total - ret_total == CREDIT_MAX)
                        else fail_check("credits left unused while returns were withheld");
                end
            end else begin
                foreach (due_q[i]) begin
                    if (idx < 0 && due_q[i] <= cyc) begin
                        idx = i;
                    end
                end
            end
            if (idx >= 0) begin
                due_q.delete(idx);
                ret_total++;
                credit_return <= 1'b1;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all frames were drained");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'h84c3));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        r_inv    = find_r_inv();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        for (int f = 0; f < N_FRAMES; f++) begin
            while (busy) begin
                @(negedge clk);
            end
            send_frame(f);
            wait (frames_done > f);
        end
        // give the busy check after the last output time to run
        repeat (2) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule
